/* Makefile */
# Verilator build and run for the memory stage testbench

VERILATOR ?= verilator
TOP       ?= mem_stage_tb
FILELIST  ?= mem_stage.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= TEST RESULT: PASS
VFLAGS    ?= --binary --timing -j 0
LINTFLAGS ?= --lint-only --timing

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

# The log decides the result, so a crash without the pass line fails too
run: build
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "Simulation did not pass, see $(LOG)"; exit 1)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* common/cpu_pkg.sv */
package cpu_pkg;

    // Datapath width
    // Data words and full byte addresses share it
    localparam int WORD_BITS = 32;

    // Register file has 32 entries
    localparam int REG_IDX_BITS = 5;

    // Data RAM depth, as a word address width
    localparam int RAM_ADDR_BITS = 8;

    // Number of words in the data RAM
    localparam int RAM_WORDS = 1 << RAM_ADDR_BITS;

    // Byte offset bits below the word address
    // Only word accesses exist, so these are dropped
    localparam int WORD_ADDR_LSB = 2;

    // One data word
    typedef logic [WORD_BITS-1:0] word_t;

    // Register number
    typedef logic [REG_IDX_BITS-1:0] reg_idx_t;

    // Word address into the data RAM
    typedef logic [RAM_ADDR_BITS-1:0] ram_addr_t;

endpackage

/* common/mem_pkg.sv */
package mem_pkg;

    // Kind of memory operation carried by a packet
    typedef enum logic [1:0] {
        // Pass-through, execute result goes on to write-back
        MEM_NONE  = 2'd0,
        // Read a RAM word into a register
        MEM_LOAD  = 2'd1,
        // Write regb into the RAM
        MEM_STORE = 2'd2
    } mem_op_e;

    // Issue/execute into the memory stage
    typedef struct packed {
        // Operation present this cycle
        logic             valid;
        mem_op_e          op;
        // Base register value
        cpu_pkg::word_t   rega;
        // Sign-extended immediate offset
        cpu_pkg::word_t   imedext;
        // Store data or execute result
        cpu_pkg::word_t   regb;
        // Destination register
        cpu_pkg::reg_idx_t regdest;
        // Register write enable
        logic             writereg;
    } iss_mem_t;

    // Address sub-stage to access sub-stage
    typedef struct packed {
        logic              valid;
        mem_op_e           op;
        // Effective word address
        cpu_pkg::ram_addr_t data_addr;
        cpu_pkg::word_t     regb;
        cpu_pkg::reg_idx_t  regdest;
        logic               writereg;
    } m0_m1_t;

    // Memory stage to write-back
    typedef struct packed {
        // Already gated by valid
        logic              writereg;
        cpu_pkg::reg_idx_t regdest;
        // Value for the register file
        cpu_pkg::word_t    wbvalue;
    } mem_wb_t;

endpackage

/* dv/mem_stage_input.txt */
# Columns in hex: ram_clear valid op rega imedext regb regdest writereg, then expected writereg regdest wbvalue
# op 0 none, 1 load, 2 store; regb of loads is replaced by a random word
0 0 0 00000000 00000000 00000000 00 0 0 00 00000000
0 0 0 00000000 00000000 00000000 00 0 0 00 00000000
0 1 2 00000100 00000000 cafef00d 00 0 0 00 00000000
0 1 1 00000108 fffffff8 00000000 05 1 1 05 cafef00d
0 1 2 00000200 00000004 11112222 00 0 0 00 00000000
0 1 2 00000200 00000008 33334444 00 0 0 00 00000000
0 1 1 00000204 00000000 00000000 06 1 1 06 11112222
0 1 1 00000210 fffffff8 00000000 07 1 1 07 33334444
0 1 0 00000000 00000000 deadbeef 0a 1 1 0a deadbeef
0 1 0 00000000 00000000 0badf00d 0b 0 0 00 00000000
0 0 0 00000000 00000000 ffffffff 0c 1 0 00 00000000
0 1 1 00000100 00000003 00000000 08 1 1 08 cafef00d
0 1 1 00000205 00000002 00000000 09 1 1 09 11112222
0 1 2 00000300 00000000 55556666 00 0 0 00 00000000
1 0 0 00000000 00000000 00000000 00 0 0 00 00000000
0 1 1 00000100 00000000 00000000 01 1 1 01 00000000
0 1 1 00000300 00000000 00000000 02 1 1 02 00000000
0 1 1 00000204 00000000 00000000 03 1 1 03 00000000
0 1 2 00000400 00000000 a5a5a5a5 00 0 0 00 00000000
0 1 1 00000000 00000000 00000000 1f 1 1 1f a5a5a5a5
0 1 0 00000000 00000000 01234567 10 1 1 10 01234567
0 0 0 00000000 00000000 00000000 00 0 0 00 00000000
0 0 0 00000000 00000000 00000000 00 0 0 00 00000000

/* dv/mem_stage_tb.sv */
`timescale 1ns/1ps

module mem_stage_tb;

    import cpu_pkg::*;
    import mem_pkg::*;

    // Clock period in ns
    localparam int CLK_PERIOD = 100;
    // Inputs change this long after a rising edge
    localparam int DRIVE_DELAY = 1;
    localparam int RESET_CYCLES = 2;
    // Extra cycles the watchdog allows beyond the vector count
    localparam int WATCHDOG_SLACK = 10;
    localparam string VECTOR_FILE = "dv/mem_stage_input.txt";

    // DUT ports
    logic     clock;
    logic     reset;
    logic     ram_clear;
    iss_mem_t iss_mem;
    mem_wb_t  mem_wb;

    // One queue entry per data file line
    logic     clear_q[$];
    iss_mem_t stim_q[$];
    mem_wb_t  expect_q[$];

    int       vec_count;
    // Index of the vector under check
    // Stays at -1 during reset
    int       cur_vec;
    bit       loaded;
    integer   seed;

    mem_stage DUT (
        .clock     (clock),
        .reset     (reset),
        .ram_clear (ram_clear),
        .iss_mem   (iss_mem),
        .mem_wb    (mem_wb)
    );

    // 100 ns clock
    always begin
        #(CLK_PERIOD / 2) clock = ~clock;
    end

    // Print the fail line and stop
    task automatic abort_run;
        $display("TEST RESULT: FAIL");
        $fatal(1, "Run stopped at the first error");
    endtask

    task automatic writereg_cmp(input logic exp, input logic act);
        if (act !== exp) begin
            $display("ERR mem_wb.writereg vector %0d expected %h actual %h", cur_vec, exp, act);
            abort_run();
        end
    endtask

    task automatic regdest_cmp(input reg_idx_t exp, input reg_idx_t act);
        if (act !== exp) begin
            $display("ERR mem_wb.regdest vector %0d expected %h actual %h", cur_vec, exp, act);
            abort_run();
        end
    endtask

    task automatic wbvalue_cmp(input word_t exp, input word_t act);
        if (act !== exp) begin
            $display("ERR mem_wb.wbvalue vector %0d expected %h actual %h", cur_vec, exp, act);
            abort_run();
        end
    endtask

    // Payload only matters when a register write is expected
    task automatic check_wb(input mem_wb_t exp);
        writereg_cmp(exp.writereg, mem_wb.writereg);
        if (exp.writereg) begin
            regdest_cmp(exp.regdest, mem_wb.regdest);
            wbvalue_cmp(exp.wbvalue, mem_wb.wbvalue);
        end
    endtask

    // Read the whole data file before the clock starts mattering
    task automatic load_vectors;
        int          fd;
        int          n;
        string       line;
        logic [31:0] f_clr, f_valid, f_op, f_rega, f_imm, f_regb, f_rd, f_wr;
        logic [31:0] e_wr, e_rd, e_val;
        iss_mem_t    stim;
        mem_wb_t     exp;
        fd = $fopen(VECTOR_FILE, "r");
        if (fd == 0) begin
            $display("Could not open the vector file %s", VECTOR_FILE);
            abort_run();
        end else begin
            while (!$feof(fd)) begin
                line = "";
                void'($fgets(line, fd));
                n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h",
                            f_clr, f_valid, f_op, f_rega, f_imm, f_regb, f_rd, f_wr,
                            e_wr, e_rd, e_val);
                // Comment and blank lines give fewer fields
                if (n == 11) begin
                    stim.valid    = f_valid[0];
                    stim.op       = mem_op_e'(f_op[1:0]);
                    stim.rega     = f_rega;
                    stim.imedext  = f_imm;
                    stim.regb     = f_regb;
                    stim.regdest  = f_rd[REG_IDX_BITS-1:0];
                    stim.writereg = f_wr[0];
                    // A load ignores regb so it gets random filler
                    if (stim.op == MEM_LOAD) begin
                        stim.regb = $random(seed);
                    end
                    exp.writereg = e_wr[0];
                    exp.regdest  = e_rd[REG_IDX_BITS-1:0];
                    exp.wbvalue  = e_val;
                    clear_q.push_back(f_clr[0]);
                    stim_q.push_back(stim);
                    expect_q.push_back(exp);
                end
            end
            $fclose(fd);
        end
        vec_count = stim_q.size();
    endtask

    task automatic drive_vector(input int idx);
        ram_clear = clear_q[idx];
        iss_mem   = stim_q[idx];
    endtask

    task automatic drive_idle;
        ram_clear = 1'b0;
        iss_mem   = '0;
    endtask

    // Main sequence
    initial begin
        clock     = 1'b0;
        reset     = 1'b1;
        ram_clear = 1'b0;
        iss_mem   = '0;
        seed      = 32'h4165;
        cur_vec   = -1;
        loaded    = 1'b0;
        load_vectors();
        if (vec_count == 0) begin
            $display("The vector file holds no vectors");
            abort_run();
        end
        loaded = 1'b1;

        // Write enable is low from the first reset edge on
        @(posedge clock);
        #DRIVE_DELAY;
        check_wb('0);
        repeat (RESET_CYCLES - 1) @(posedge clock);
        #DRIVE_DELAY;
        reset = 1'b0;
        drive_vector(0);

        // Line n is checked two edges after it is driven
        for (int k = 1; k <= vec_count + 1; k++) begin
            @(posedge clock);
            #DRIVE_DELAY;
            if (k >= 2) begin
                cur_vec = k - 2;
                check_wb(expect_q[k-2]);
            end
            if (k < vec_count) begin
                drive_vector(k);
            end else begin
                drive_idle();
            end
        end

        $display("TEST RESULT: PASS");
        $finish;
    end

    // Watchdog sized from the vector count
    initial begin
        wait (loaded);
        #((vec_count + WATCHDOG_SLACK) * CLK_PERIOD);
        $display("Watchdog timeout before all vectors were checked");
        abort_run();
    end

endmodule

/* mem_stage.f */
common/cpu_pkg.sv
common/mem_pkg.sv
mem_stage/mem_addr_stage.sv
mem_stage/mem_access_stage.sv
mem_stage/data_ram.sv
mem_stage/mem_stage.sv
dv/mem_stage_tb.sv

/* mem_stage/data_ram.sv */
`timescale 1ns/1ps

module data_ram (
    input  logic               clock,
    // Synchronous clear of the whole array
    input  logic               ram_clear,
    // Write port
    input  logic               we,
    // Shared read and write address
    input  cpu_pkg::ram_addr_t addr,
    input  cpu_pkg::word_t     wdata,
    // Combinational read
    output cpu_pkg::word_t     rdata
);

    import cpu_pkg::*;

    // Storage, one word per address
    word_t mem [RAM_WORDS];

    // Asynchronous read
    // A store is only visible after its edge
    assign rdata = mem[addr];

    // Write and clear
    always_ff @(posedge clock) begin
        if (ram_clear) begin
            // Zero every word in one edge
            // Wins over a store in the same cycle
            for (int i = 0; i < RAM_WORDS; i++) begin
                mem[i] <= '0;
            end
        end else if (we) begin
            // Single word store
            mem[addr] <= wdata;
        end
    end

endmodule

/* mem_stage/mem_access_stage.sv */
`timescale 1ns/1ps

module mem_access_stage (
    input  logic               clock,
    input  logic               reset,

    // Packet from the address sub-stage
    input  mem_pkg::m0_m1_t    m0_m1,

    // Data RAM port
    output logic               ram_we,
    output cpu_pkg::ram_addr_t ram_addr,
    output cpu_pkg::word_t     ram_wdata,
    // Read word, valid in the same cycle as ram_addr
    input  cpu_pkg::word_t     ram_rdata,

    // Packet to write-back
    output mem_pkg::mem_wb_t   mem_wb
);

    import cpu_pkg::*;
    import mem_pkg::*;

    // Op decode
    logic is_store;
    // Selected write-back value
    word_t wb_value;

    // Only a valid store touches the RAM
    assign is_store = m0_m1.valid && (m0_m1.op == MEM_STORE);

    // Write strobe lands on the closing edge of this cycle
    assign ram_we = is_store;

    // One address for read and write
    assign ram_addr = m0_m1.data_addr;

    // Store data is regb
    assign ram_wdata = m0_m1.regb;

    // Write-back source by op
    always_comb begin
        unique case (m0_m1.op)
            // RAM word, read combinationally this cycle
            MEM_LOAD: begin
                wb_value = ram_rdata;
            end
            // Execute result passes straight through
            MEM_NONE: begin
                wb_value = m0_m1.regb;
            end
            // Nothing useful to return for a store
            MEM_STORE: begin
                wb_value = '0;
            end
            default: begin
                wb_value = '0;
            end
        endcase
    end

    // Write-back register
    always_ff @(posedge clock) begin
        // Write enable is the only control bit
        // Gated by valid so bubbles never write a register
        if (reset) begin
            mem_wb.writereg <= 1'b0;
        end else begin
            mem_wb.writereg <= m0_m1.valid && m0_m1.writereg;
        end

        // Payload
        mem_wb.regdest <= m0_m1.regdest;
        mem_wb.wbvalue <= wb_value;
    end

endmodule

/* mem_stage/mem_addr_stage.sv */
`timescale 1ns/1ps

module mem_addr_stage (
    input  logic              clock,
    input  logic              reset,
    // Operation from issue/execute
    input  mem_pkg::iss_mem_t iss_mem,
    // Registered packet for the access sub-stage
    output mem_pkg::m0_m1_t   m0_m1
);

    import cpu_pkg::*;

    // Full byte address, base plus offset
    word_t     eff_addr;
    // Word address bits of the sum
    ram_addr_t word_addr;

    // Address adder
    // Negative offsets work through the sign-extended immediate
    assign eff_addr = iss_mem.rega + iss_mem.imedext;

    // Drop the byte offset and the bits above the RAM depth
    // Upper bits simply wrap
    assign word_addr = eff_addr[WORD_ADDR_LSB +: RAM_ADDR_BITS];

    // Pipeline register between the sub-stages
    always_ff @(posedge clock) begin
        // Control bit
        if (reset) begin
            m0_m1.valid <= 1'b0;
        end else begin
            m0_m1.valid <= iss_mem.valid;
        end

        // Payload follows the input every cycle
        // Meaningless while valid is low
        m0_m1.op        <= iss_mem.op;
        m0_m1.data_addr <= word_addr;
        m0_m1.regb      <= iss_mem.regb;
        m0_m1.regdest   <= iss_mem.regdest;
        m0_m1.writereg  <= iss_mem.writereg;
    end

endmodule

/* mem_stage/mem_stage.sv */
`timescale 1ns/1ps

module mem_stage (
    input  logic              clock,
    input  logic              reset,
    // Zeroes the data RAM while high
    input  logic              ram_clear,
    // Operation in from issue/execute
    input  mem_pkg::iss_mem_t iss_mem,
    // Result out to write-back, two cycles later
    output mem_pkg::mem_wb_t  mem_wb
);

    import cpu_pkg::*;
    import mem_pkg::*;

    // Between the sub-stages
    m0_m1_t    m0_m1;

    // RAM port
    logic      ram_we;
    ram_addr_t ram_addr;
    word_t     ram_wdata;
    word_t     ram_rdata;

    // Address sub-stage
    mem_addr_stage u_addr (
        .clock   (clock),
        .reset   (reset),
        .iss_mem (iss_mem),
        .m0_m1   (m0_m1)
    );

    // Access sub-stage
    mem_access_stage u_access (
        .clock     (clock),
        .reset     (reset),
        .m0_m1     (m0_m1),
        .ram_we    (ram_we),
        .ram_addr  (ram_addr),
        .ram_wdata (ram_wdata),
        .ram_rdata (ram_rdata),
        .mem_wb    (mem_wb)
    );

    // Data memory
    data_ram u_ram (
        .clock     (clock),
        .ram_clear (ram_clear),
        .we        (ram_we),
        .addr      (ram_addr),
        .wdata     (ram_wdata),
        .rdata     (ram_rdata)
    );

endmodule
